/* verilog/snow_game_pkg.sv */
`default_nettype none

package snow_game_pkg;

    typedef logic [9:0] coord_x_t;
    typedef logic [8:0] coord_y_t;
    typedef logic [1:0] health_t;
    typedef logic [1:0] score_t;

    // player box and start point
    localparam int       PLAYER_W  = 8;
    localparam int       PLAYER_H  = 8;
    localparam coord_x_t PLAYER_X0 = 10'd20;
    localparam coord_y_t PLAYER_Y0 = 9'd40;

    // floor row, then the wall, then the ledge
    localparam int       BLOCK_NUM = 6;
    localparam int       BLOCK_W   = 16;
    localparam int       BLOCK_H   = 8;
    localparam coord_x_t BLOCK_X [BLOCK_NUM] = '{10'd16, 10'd32, 10'd48, 10'd64, 10'd96, 10'd40};
    localparam coord_y_t BLOCK_Y [BLOCK_NUM] = '{9'd48, 9'd48, 9'd48, 9'd48, 9'd40, 9'd24};

    localparam int       FLAKE_NUM = 3;
    localparam int       FLAKE_W   = 4;
    localparam coord_x_t FLAKE_X [FLAKE_NUM] = '{10'd36, 10'd60, 10'd44};
    localparam coord_y_t FLAKE_Y [FLAKE_NUM] = '{9'd42, 9'd42, 9'd16};

    localparam int       MONSTER_NUM = 2;
    localparam int       MONSTER_W   = 8;
    localparam coord_x_t MONSTER_X [MONSTER_NUM] = '{10'd70, 10'd120};
    localparam coord_y_t MONSTER_Y [MONSTER_NUM] = '{9'd40, 9'd40};

    localparam health_t HEALTH_INIT = 2'd3;

    // clock cycles per movement step
    localparam int STEP_CYCLES = 4;
    localparam int STEP_CNT_W  = $clog2(STEP_CYCLES);

    // bit positions in the held and blocked vectors
    localparam int DIR_UP    = 0;
    localparam int DIR_LEFT  = 1;
    localparam int DIR_DOWN  = 2;
    localparam int DIR_RIGHT = 3;

    typedef enum logic [7:0] {
        KEY_W = 8'h1D,
        KEY_A = 8'h1C,
        KEY_S = 8'h1B,
        KEY_D = 8'h23,
        KEY_R = 8'h2D
    } key_code_e;

    typedef enum logic [1:0] {
        GAME_IDLE,
        GAME_PLAY,
        GAME_WON,
        GAME_LOST
    } game_state_e;

    // player box against one object box, one bit per side of the player
    function automatic logic [3:0] side_contact(coord_x_t px, coord_y_t py,
                                                coord_x_t ox, coord_y_t oy,
                                                int ow, int oh);
        logic       x_ov;
        logic       y_ov;
        logic [3:0] side;
        x_ov = (px < ox + ow) && (ox < px + PLAYER_W);
        y_ov = (py < oy + oh) && (oy < py + PLAYER_H);
        side[DIR_UP]    = x_ov && (py == oy + oh);
        side[DIR_LEFT]  = y_ov && (px == ox + ow);
        side[DIR_DOWN]  = x_ov && (py + PLAYER_H == oy);
        side[DIR_RIGHT] = y_ov && (px + PLAYER_W == ox);
        return side;
    endfunction

    function automatic logic box_overlap(coord_x_t px, coord_y_t py,
                                         coord_x_t ox, coord_y_t oy, int ow, int oh);
        return (px < ox + ow) && (ox < px + PLAYER_W)
            && (py < oy + oh) && (oy < py + PLAYER_H);
    endfunction

endpackage

`default_nettype wire

/* verilog/key_decoder.sv */
`default_nettype none

module key_decoder import snow_game_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n_i,
    input  wire logic       key_valid_i,
    input  wire logic [7:0] key_code_i,
    input  wire logic       key_release_i,
    output logic      [3:0] held_o,
    output logic            restart_o
);

    logic [3:0] held_q;
    logic       restart_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            held_q    <= '0;
            restart_q <= 1'b0;
        end else begin
            restart_q <= 1'b0;
            if (key_valid_i) begin
                case (key_code_i)
                    KEY_W:   held_q[DIR_UP]    <= !key_release_i;
                    KEY_A:   held_q[DIR_LEFT]  <= !key_release_i;
                    KEY_S:   held_q[DIR_DOWN]  <= !key_release_i;
                    KEY_D:   held_q[DIR_RIGHT] <= !key_release_i;
                    // a repeated press while pulsing is dropped
                    KEY_R:   restart_q <= !key_release_i && !restart_q;
                    default: ;
                endcase
            end
        end
    end

    // left beats right, up beats down
    always_comb begin
        held_o = held_q;
        if (held_q[DIR_LEFT]) begin
            held_o[DIR_RIGHT] = 1'b0;
        end
        if (held_q[DIR_UP]) begin
            held_o[DIR_DOWN] = 1'b0;
        end
    end

    assign restart_o = restart_q;

    a_restart_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        restart_o |=> !restart_o);

endmodule

`default_nettype wire

/* verilog/block_contact.sv */
`default_nettype none

module block_contact import snow_game_pkg::*; (
    input  wire logic           clk,
    input  wire logic           rst_n_i,
    input  wire logic           restart_i,
    input  wire coord_x_t       x_i,
    input  wire coord_y_t       y_i,
    output logic [3:0]          blocked_o,
    output logic [BLOCK_NUM-1:0] iced_o,
    output logic                all_iced_o
);

    logic [BLOCK_NUM-1:0][3:0] side;
    logic [BLOCK_NUM-1:0]      on_top;
    logic [3:0]                side_any;
    logic [3:0]                blocked_q;
    logic [BLOCK_NUM-1:0]      iced_q;

    for (genvar i = 0; i < BLOCK_NUM; i++) begin : g_block
        assign side[i]   = side_contact(x_i, y_i, BLOCK_X[i], BLOCK_Y[i], BLOCK_W, BLOCK_H);
        assign on_top[i] = side[i][DIR_DOWN];
    end

    // any block on a side blocks that side
    always_comb begin
        side_any = '0;
        for (int i = 0; i < BLOCK_NUM; i++) begin
            side_any = side_any | side[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            blocked_q <= '0;
            iced_q    <= '0;
        end else if (restart_i) begin
            blocked_q <= '0;
            iced_q    <= '0;
        end else begin
            blocked_q <= side_any;
            // sticky until the next restart
            iced_q    <= iced_q | on_top;
        end
    end

    assign blocked_o  = blocked_q;
    assign iced_o     = iced_q;
    assign all_iced_o = &iced_q;

endmodule

`default_nettype wire

/* verilog/player_motion.sv */
`default_nettype none

module player_motion import snow_game_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n_i,
    input  wire logic       restart_i,
    input  wire logic       playing_i,
    input  wire logic [3:0] held_i,
    input  wire logic [3:0] blocked_i,
    output coord_x_t        x_o,
    output coord_y_t        y_o,
    output logic            step_o
);

    logic [STEP_CNT_W-1:0] step_cnt_q;
    logic                  step;
    coord_x_t              x_q;
    coord_y_t              y_q;

    assign step = (step_cnt_q == STEP_CNT_W'(STEP_CYCLES - 1));

    // step pacing, phase fixed by restart
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            step_cnt_q <= '0;
        end else if (restart_i || step) begin
            step_cnt_q <= '0;
        end else begin
            step_cnt_q <= step_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            x_q <= PLAYER_X0;
            y_q <= PLAYER_Y0;
        end else if (restart_i) begin
            x_q <= PLAYER_X0;
            y_q <= PLAYER_Y0;
        end else if (step && playing_i) begin
            if (held_i[DIR_LEFT] && !blocked_i[DIR_LEFT]) begin
                x_q <= x_q - 1'b1;
            end else if (held_i[DIR_RIGHT] && !blocked_i[DIR_RIGHT]) begin
                x_q <= x_q + 1'b1;
            end
            // y grows downward
            if (held_i[DIR_UP] && !blocked_i[DIR_UP]) begin
                y_q <= y_q - 1'b1;
            end else if (held_i[DIR_DOWN] && !blocked_i[DIR_DOWN]) begin
                y_q <= y_q + 1'b1;
            end
        end
    end

    assign x_o    = x_q;
    assign y_o    = y_q;
    assign step_o = step;

    a_one_pixel: assert property (@(posedge clk) disable iff (!rst_n_i)
        !restart_i |=>
            ((x_o == $past(x_o)) || (x_o == $past(x_o) + 1'b1) || (x_o == $past(x_o) - 1'b1))
         && ((y_o == $past(y_o)) || (y_o == $past(y_o) + 1'b1) || (y_o == $past(y_o) - 1'b1)));

endmodule

`default_nettype wire

/* verilog/snowflake_pickup.sv */
`default_nettype none

module snowflake_pickup import snow_game_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n_i,
    input  wire logic     restart_i,
    input  wire coord_x_t x_i,
    input  wire coord_y_t y_i,
    output score_t        score_o
);

    logic [FLAKE_NUM-1:0] hit;
    logic [FLAKE_NUM-1:0] collected_q;
    score_t               score_q;
    score_t               collected_cnt;

    for (genvar i = 0; i < FLAKE_NUM; i++) begin : g_flake
        assign hit[i] = box_overlap(x_i, y_i, FLAKE_X[i], FLAKE_Y[i], FLAKE_W, FLAKE_W);
    end

    // each flake counts once, so the score follows the collected flags
    always_comb begin
        collected_cnt = '0;
        for (int i = 0; i < FLAKE_NUM; i++) begin
            collected_cnt = collected_cnt + score_t'(collected_q[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            collected_q <= '0;
            score_q     <= '0;
        end else if (restart_i) begin
            collected_q <= '0;
            score_q     <= '0;
        end else begin
            collected_q <= collected_q | hit;
            score_q     <= collected_cnt;
        end
    end

    assign score_o = score_q;

endmodule

`default_nettype wire

/* verilog/monster_contact.sv */
`default_nettype none

module monster_contact import snow_game_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_n_i,
    input  wire logic              restart_i,
    input  wire coord_x_t          x_i,
    input  wire coord_y_t          y_i,
    output logic [3:0]             blocked_o,
    output logic [MONSTER_NUM-1:0] frozen_o,
    output health_t                health_o
);

    logic [MONSTER_NUM-1:0][3:0] side;
    logic [MONSTER_NUM-1:0]      on_top;
    logic [MONSTER_NUM-1:0]      touch;
    logic [3:0]                  side_any;
    logic [3:0]                  blocked_q;
    logic [MONSTER_NUM-1:0]      frozen_q;
    logic [MONSTER_NUM-1:0]      touch_q;
    logic [MONSTER_NUM-1:0]      touch_d;
    health_t                     health_q;

    for (genvar i = 0; i < MONSTER_NUM; i++) begin : g_monster
        assign side[i]   = side_contact(x_i, y_i, MONSTER_X[i], MONSTER_Y[i],
                                        MONSTER_W, MONSTER_W);
        assign on_top[i] = side[i][DIR_DOWN];
        // frozen monsters are harmless from the side
        assign touch[i]  = (side[i][DIR_LEFT] || side[i][DIR_RIGHT]) && !frozen_q[i];
    end

    // monsters are solid, frozen or not
    always_comb begin
        side_any = '0;
        for (int i = 0; i < MONSTER_NUM; i++) begin
            side_any = side_any | side[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            blocked_q <= '0;
            frozen_q  <= '0;
            touch_q   <= '0;
            touch_d   <= '0;
            health_q  <= HEALTH_INIT;
        end else if (restart_i) begin
            blocked_q <= '0;
            frozen_q  <= '0;
            touch_q   <= '0;
            touch_d   <= '0;
            health_q  <= HEALTH_INIT;
        end else begin
            blocked_q <= side_any;
            frozen_q  <= frozen_q | on_top;
            touch_q   <= touch;
            touch_d   <= touch_q;
            // one point per new contact, floor at zero
            if (|(touch_q & ~touch_d) && health_q != '0) begin
                health_q <= health_q - 1'b1;
            end
        end
    end

    assign blocked_o = blocked_q;
    assign frozen_o  = frozen_q;
    assign health_o  = health_q;

    a_health_no_rise: assert property (@(posedge clk) disable iff (!rst_n_i)
        !restart_i |=> (health_o <= $past(health_o)));

endmodule

`default_nettype wire

/* verilog/game_fsm.sv */
`default_nettype none

module game_fsm import snow_game_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst_n_i,
    input  wire logic    restart_i,
    input  wire logic    all_iced_i,
    input  wire health_t health_i,
    output game_state_e  state_o,
    output logic         playing_o
);

    game_state_e state_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= GAME_IDLE;
        end else if (restart_i) begin
            state_q <= GAME_PLAY;
        end else if (state_q == GAME_PLAY) begin
            // losing wins the tie
            if (health_i == '0) begin
                state_q <= GAME_LOST;
            end else if (all_iced_i) begin
                state_q <= GAME_WON;
            end
        end
    end

    assign state_o   = state_q;
    assign playing_o = (state_q == GAME_PLAY);

endmodule

`default_nettype wire

/* verilog/snow_game_top.sv */
`default_nettype none

module snow_game_top import snow_game_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_n_i,
    input  wire logic              key_valid_i,
    input  wire logic [7:0]        key_code_i,
    input  wire logic              key_release_i,
    output coord_x_t               player_x_o,
    output coord_y_t               player_y_o,
    output score_t                 score_o,
    output health_t                health_o,
    output logic [BLOCK_NUM-1:0]   iced_o,
    output logic [MONSTER_NUM-1:0] frozen_o,
    output game_state_e            game_state_o
);

    logic [3:0] held;
    logic       restart;
    logic       playing;
    logic [3:0] block_blocked;
    logic [3:0] monster_blocked;
    logic       all_iced;

    key_decoder u_key_decoder (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .key_valid_i   (key_valid_i),
        .key_code_i    (key_code_i),
        .key_release_i (key_release_i),
        .held_o        (held),
        .restart_o     (restart)
    );

    // blocks and monsters both stop the player
    player_motion u_player_motion (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .restart_i (restart),
        .playing_i (playing),
        .held_i    (held),
        .blocked_i (block_blocked | monster_blocked),
        .x_o       (player_x_o),
        .y_o       (player_y_o),
        .step_o    ()
    );

    block_contact u_block_contact (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .restart_i  (restart),
        .x_i        (player_x_o),
        .y_i        (player_y_o),
        .blocked_o  (block_blocked),
        .iced_o     (iced_o),
        .all_iced_o (all_iced)
    );

    snowflake_pickup u_snowflake_pickup (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .restart_i (restart),
        .x_i       (player_x_o),
        .y_i       (player_y_o),
        .score_o   (score_o)
    );

    monster_contact u_monster_contact (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .restart_i (restart),
        .x_i       (player_x_o),
        .y_i       (player_y_o),
        .blocked_o (monster_blocked),
        .frozen_o  (frozen_o),
        .health_o  (health_o)
    );

    game_fsm u_game_fsm (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .restart_i  (restart),
        .all_iced_i (all_iced),
        .health_i   (health_o),
        .state_o    (game_state_o),
        .playing_o  (playing)
    );

endmodule

`default_nettype wire

/* dv/tb_snow_game.sv */
`default_nettype none

module tb_snow_game import snow_game_pkg::*; ();

    localparam int CLK_PERIOD      = 40;
    // steps per test, the random monster rounds dominate
    localparam int TEST_STEPS      = 50 + 145 + 85 + 45 + 40 * 12 + 10;
    localparam int WATCHDOG_CYCLES = TEST_STEPS * STEP_CYCLES * 3 / 2 + 200;
    localparam logic [7:0] DIR_KEY [4] = '{KEY_W, KEY_A, KEY_S, KEY_D};

    logic                   clk;
    logic                   rst_n_i;
    logic                   key_valid_i;
    logic [7:0]             key_code_i;
    logic                   key_release_i;
    coord_x_t               player_x;
    coord_y_t               player_y;
    score_t                 score;
    health_t                health;
    logic [BLOCK_NUM-1:0]   iced;
    logic [MONSTER_NUM-1:0] frozen;
    game_state_e            game_state;

    // reference model state
    int                     m_x;
    int                     m_y;
    int                     m_score;
    int                     m_health;
    logic [BLOCK_NUM-1:0]   m_iced;
    logic [MONSTER_NUM-1:0] m_frozen;
    logic [FLAKE_NUM-1:0]   m_collected;
    logic [MONSTER_NUM-1:0] m_touch;
    logic [3:0]             m_held;
    game_state_e            m_state;

    int   errors;
    int   checks;
    int   test_errors;
    event cmp_ev;

    snow_game_top u_dut (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .key_valid_i   (key_valid_i),
        .key_code_i    (key_code_i),
        .key_release_i (key_release_i),
        .player_x_o    (player_x),
        .player_y_o    (player_y),
        .score_o       (score),
        .health_o      (health),
        .iced_o        (iced),
        .frozen_o      (frozen),
        .game_state_o  (game_state)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // a span runs from its corner to corner plus length minus one
    function automatic logic span_hit(int a, int alen, int b, int blen);
        return (a <= b + blen - 1) && (b <= a + alen - 1);
    endfunction

    // player sides touching a box: up, left, down, right
    function automatic logic [3:0] sides(int ox, int oy, int ow, int oh);
        logic [3:0] s;
        s[0] = span_hit(m_x, PLAYER_W, ox, ow) && (m_y == oy + oh);
        s[1] = span_hit(m_y, PLAYER_H, oy, oh) && (m_x == ox + ow);
        s[2] = span_hit(m_x, PLAYER_W, ox, ow) && (m_y + PLAYER_H == oy);
        s[3] = span_hit(m_y, PLAYER_H, oy, oh) && (m_x + PLAYER_W == ox);
        return s;
    endfunction

    function automatic void update_contacts();
        logic [MONSTER_NUM-1:0] touch;
        logic [3:0]             s;
        for (int i = 0; i < BLOCK_NUM; i++) begin
            s = sides(BLOCK_X[i], BLOCK_Y[i], BLOCK_W, BLOCK_H);
            m_iced[i] = m_iced[i] | s[2];
        end
        for (int i = 0; i < MONSTER_NUM; i++) begin
            s = sides(MONSTER_X[i], MONSTER_Y[i], MONSTER_W, MONSTER_W);
            touch[i] = (s[1] | s[3]) & !m_frozen[i];
            m_frozen[i] = m_frozen[i] | s[2];
        end
        for (int i = 0; i < FLAKE_NUM; i++) begin
            m_collected[i] = m_collected[i]
                | (span_hit(m_x, PLAYER_W, FLAKE_X[i], FLAKE_W)
                && span_hit(m_y, PLAYER_H, FLAKE_Y[i], FLAKE_W));
        end
        m_score = $countones(m_collected);
        // damage only when a contact begins
        if ((touch & ~m_touch) != '0 && m_health > 0) begin
            m_health--;
        end
        m_touch = touch;
    endfunction

    function automatic void reset_model(game_state_e st);
        m_x         = PLAYER_X0;
        m_y         = PLAYER_Y0;
        m_health    = HEALTH_INIT;
        m_iced      = '0;
        m_frozen    = '0;
        m_collected = '0;
        m_touch     = '0;
        m_state     = st;
        update_contacts();
    endfunction

    // next model state after one movement step with these keys held
    function automatic void predict_step(logic [3:0] held);
        logic [3:0] eff;
        logic [3:0] blk;
        eff = held;
        if (eff[1]) begin
            eff[3] = 1'b0;
        end
        if (eff[0]) begin
            eff[2] = 1'b0;
        end
        blk = '0;
        for (int i = 0; i < BLOCK_NUM; i++) begin
            blk = blk | sides(BLOCK_X[i], BLOCK_Y[i], BLOCK_W, BLOCK_H);
        end
        for (int i = 0; i < MONSTER_NUM; i++) begin
            blk = blk | sides(MONSTER_X[i], MONSTER_Y[i], MONSTER_W, MONSTER_W);
        end
        if (m_state == GAME_PLAY) begin
            if (eff[1] && !blk[1]) begin
                m_x--;
            end else if (eff[3] && !blk[3]) begin
                m_x++;
            end
            if (eff[0] && !blk[0]) begin
                m_y--;
            end else if (eff[2] && !blk[2]) begin
                m_y++;
            end
        end
        update_contacts();
        if (m_state == GAME_PLAY) begin
            if (m_health == 0) begin
                m_state = GAME_LOST;
            end else if (&m_iced) begin
                m_state = GAME_WON;
            end
        end
    endfunction

    task automatic report_mismatch(input string name, input int got, input int exp);
        $display("MISMATCH %s: dut %h expected %h at %0t", name, got, exp, $time);
        errors++;
        test_errors++;
    endtask

    // comparator, runs once the step has settled
    always begin
        @(cmp_ev);
        repeat (3) @(posedge clk);
        @(negedge clk);
        checks++;
        if (player_x != m_x) report_mismatch("player_x_o", player_x, m_x);
        if (player_y != m_y) report_mismatch("player_y_o", player_y, m_y);
        if (score != m_score) report_mismatch("score_o", score, m_score);
        if (health != m_health) report_mismatch("health_o", health, m_health);
        if (iced != m_iced) report_mismatch("iced_o", iced, m_iced);
        if (frozen != m_frozen) report_mismatch("frozen_o", frozen, m_frozen);
        if (game_state != m_state) report_mismatch("game_state_o", game_state, m_state);
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // called 5 time units after a rising edge
    task automatic key_event(input logic [7:0] code, input logic release_flag);
        key_valid_i   = 1'b1;
        key_code_i    = code;
        key_release_i = release_flag;
        @(posedge clk);
        #5;
        key_valid_i = 1'b0;
    endtask

    task automatic move_step(input logic [3:0] want);
        int n;
        n = 0;
        for (int d = 0; d < 4; d++) begin
            if (want[d] != m_held[d]) begin
                key_event(DIR_KEY[d], !want[d]);
                n++;
            end
        end
        m_held = want;
        if (n > STEP_CYCLES - 1) begin
            $display("too many key changes before one step");
            errors++;
            test_errors++;
        end
        repeat (STEP_CYCLES - n) @(posedge clk);
        #5;
        predict_step(m_held);
        ->cmp_ev;
    endtask

    task automatic walk(input logic [3:0] want, input int steps);
        repeat (steps) move_step(want);
    endtask

    task automatic wait_settled();
        repeat (STEP_CYCLES) @(negedge clk);
    endtask

    task automatic resume_step();
        @(posedge clk);
        #5;
        predict_step(m_held);
        ->cmp_ev;
    endtask

    task automatic restart_game();
        wait_settled();
        @(posedge clk);
        #5;
        key_event(KEY_R, 1'b0);
        @(posedge clk);
        #5;
        reset_model(GAME_PLAY);
        ->cmp_ev;
    endtask

    task automatic check_restart();
        wait_settled();
        if (player_x != PLAYER_X0) report_mismatch("player_x_o", player_x, PLAYER_X0);
        if (player_y != PLAYER_Y0) report_mismatch("player_y_o", player_y, PLAYER_Y0);
        if (health != HEALTH_INIT) report_mismatch("health_o", health, HEALTH_INIT);
        if (score != 0) report_mismatch("score_o", score, 0);
        if (frozen != '0) report_mismatch("frozen_o", frozen, 0);
        if (game_state != GAME_PLAY) report_mismatch("game_state_o", game_state, GAME_PLAY);
        resume_step();
    endtask

    task automatic finish_test(input string name);
        $display("test %s: %s (%0d errors)", name, test_errors == 0 ? "ok" : "failed",
                 test_errors);
        test_errors = 0;
    endtask

    initial begin
        int unsigned seed;
        int          len;
        int          sx;
        int          sy;
        seed          = $urandom(32'ha17347dc);
        rst_n_i       = 1'b0;
        key_valid_i   = 1'b0;
        key_code_i    = '0;
        key_release_i = 1'b0;
        errors        = 0;
        checks        = 0;
        test_errors   = 0;
        m_held        = '0;
        reset_model(GAME_IDLE);
        repeat (3) @(posedge clk);
        #5;
        // reset values, before the player ices block 0
        if (iced != '0) report_mismatch("iced_o", iced, 0);
        if (frozen != '0) report_mismatch("frozen_o", frozen, 0);
        if (score != 0) report_mismatch("score_o", score, 0);
        if (game_state != GAME_IDLE) report_mismatch("game_state_o", game_state, GAME_IDLE);
        rst_n_i = 1'b1;
        ->cmp_ev;
        repeat (6) @(posedge clk);
        #5;

        // held keys do nothing while idle
        key_event(KEY_D, 1'b0);
        m_held = 4'b1000;
        repeat (12) @(posedge clk);
        #5;
        ->cmp_ev;
        repeat (5) @(posedge clk);
        #5;
        key_event(KEY_D, 1'b1);
        m_held = 4'b0000;
        restart_game();
        check_restart();
        finish_test("1 reset and start");

        walk(4'b1000, 30);
        wait_settled();
        // flake 0 passed, flake 1 still ahead
        if (score != 1) report_mismatch("score_o", score, 1);
        resume_step();
        walk(4'b1000, 14);
        wait_settled();
        if (player_x != 62) report_mismatch("player_x_o", player_x, 62);
        if (health != 2) report_mismatch("health_o", health, 2);
        resume_step();
        finish_test("2 walk right");

        // under the ledge, around it, over to the wall
        walk(4'b0010, 18);
        walk(4'b0001, 12);
        walk(4'b0010, 14);
        walk(4'b0001, 16);
        walk(4'b1000, 66);
        walk(4'b0100, 18);
        wait_settled();
        if (iced != '1) report_mismatch("iced_o", iced, 6'h3f);
        if (game_state != GAME_WON) report_mismatch("game_state_o", game_state, GAME_WON);
        resume_step();
        finish_test("3 ice all blocks");

        restart_game();
        check_restart();
        walk(4'b0001, 8);
        walk(4'b1000, 58);
        walk(4'b0100, 10);
        walk(4'b0010, 3);
        wait_settled();
        if (!frozen[0]) report_mismatch("frozen_o", frozen, 1);
        if (health != HEALTH_INIT) report_mismatch("health_o", health, HEALTH_INIT);
        resume_step();
        finish_test("4 freeze monster");

        walk(4'b0001, 8);
        walk(4'b1000, 34);
        for (int r = 0; r < 40 && m_state == GAME_PLAY; r++) begin
            len = 1 + $urandom % 6;
            walk(4'b0100, len);
            len = 1 + $urandom % 6;
            if (len > m_y - 31) begin
                len = m_y - 31;
            end
            walk(4'b0001, len);
        end
        wait_settled();
        if (game_state != GAME_LOST) report_mismatch("game_state_o", game_state, GAME_LOST);
        if (health != 0) report_mismatch("health_o", health, 0);
        sx = m_x;
        sy = m_y;
        resume_step();
        walk(4'b0001, 3);
        wait_settled();
        if (player_x != sx) report_mismatch("player_x_o", player_x, sx);
        if (player_y != sy) report_mismatch("player_y_o", player_y, sy);
        resume_step();
        finish_test("5 lose to monster");

        restart_game();
        check_restart();
        finish_test("6 restart after loss");

        wait_settled();
        $display("all tests done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
verilog/snow_game_pkg.sv
verilog/key_decoder.sv
verilog/block_contact.sv
verilog/player_motion.sv
verilog/snowflake_pickup.sv
verilog/monster_contact.sv
verilog/game_fsm.sv
verilog/snow_game_top.sv
dv/tb_snow_game.sv

/* Bender.yml */
package:
  name: snow_game

sources:
  - verilog/snow_game_pkg.sv
  - verilog/key_decoder.sv
  - verilog/block_contact.sv
  - verilog/player_motion.sv
  - verilog/snowflake_pickup.sv
  - verilog/monster_contact.sv
  - verilog/game_fsm.sv
  - verilog/snow_game_top.sv
  - target: test
    files:
      - dv/tb_snow_game.sv
